//--- bench/id_stim.mem
// tag(kind|checks) inst pc es_allowin es_meta es_data ms_meta ms_data ws_meta ws_data
// rf_meta rf_data alu flags dest imm br_kind rj rkd br(stall,taken) target flow(valid,allowin)
// decode of alu and immediate forms, with register writes on the side
91 00100823 1c000000 1 0 0 0 0 0 0 21 11111111 001 04 03 00000000 0 0 0 0 0 11
91 023ffc24 1c000004 1 0 0 0 0 0 0 22 22222222 004 05 04 ffffffff 0 0 0 0 0 11
91 0363fc45 1c000008 1 0 0 0 0 0 0 20 deadbeef 010 05 05 000008ff 0 0 0 0 0 11
91 00408c26 1c00000c 1 0 0 0 0 0 0 0 0 100 05 06 00000023 0 0 0 0 0 11
91 142468a7 1c000010 1 0 0 0 0 0 0 0 0 800 05 07 12345000 0 0 0 0 0 11
91 1c000028 1c000014 1 0 0 0 0 0 0 24 fffffff0 001 07 08 00001000 0 0 0 0 0 11
91 ffffffff 1c000018 1 0 0 0 0 0 0 0 0 000 00 00 00000000 0 0 0 0 0 11
// register file reads, r0 stays zero
b1 00100823 1c00001c 1 0 0 0 0 0 0 0 0 001 04 03 0 0 11111111 22222222 0 0 11
b1 00100409 1c000020 1 0 0 0 0 0 0 0 0 001 04 09 0 0 00000000 11111111 0 0 11
// forwarding priority
a1 00100823 1c000024 1 41 eeeeeeee 41 cccccccc 41 aaaaaaaa 0 0 0 0 0 0 0 eeeeeeee 22222222 0 0 11
a1 00100823 1c000028 1 01 eeeeeeee 41 cccccccc 41 aaaaaaaa 0 0 0 0 0 0 0 cccccccc 22222222 0 0 11
a1 00100823 1c00002c 1 0 0 0 0 42 55555555 0 0 0 0 0 0 0 11111111 55555555 0 0 11
// load-use stall on a branch, then release
c1 58001022 1c000100 1 61 11111111 0 0 0 0 0 0 0 0 0 0 0 0 0 10 1c000110 00
c2 58001022 1c000100 1 61 11111111 0 0 0 0 0 0 0 0 0 0 0 0 0 10 1c000110 00
e2 58001022 1c000100 1 41 22222222 0 0 0 0 0 0 0 0 0 0 0 22222222 22222222 01 1c000110 11
// branch kinds
c1 58001022 1c000200 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00 1c000210 11
c1 5c001022 1c000200 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 01 1c000210 11
c1 60001081 1c000200 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 01 1c000210 11
c1 64001081 1c000200 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00 1c000210 11
c1 68001081 1c000200 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00 1c000210 11
c1 6c001081 1c000200 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 01 1c000210 11
d1 4c00082b 1c000200 1 0 0 0 0 0 0 0 0 001 07 0b 00000004 7 0 0 01 11111119 11
c1 50002000 1c000200 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 01 1c000220 11
d1 54002000 1c000200 1 0 0 0 0 0 0 0 0 001 07 01 00000004 9 0 0 01 1c000220 11
// back-pressure, a pending fetch waits for es_allowin
a1 00100823 1c000300 0 0 0 0 0 0 0 0 0 0 0 0 0 0 11111111 22222222 0 0 10
a3 00100409 1c000304 0 0 0 0 0 0 0 0 0 0 0 0 0 0 11111111 22222222 0 0 10
a3 00100409 1c000304 0 0 0 0 0 0 0 0 0 0 0 0 0 0 11111111 22222222 0 0 10
a1 00100409 1c000304 1 0 0 0 0 0 0 0 0 0 0 0 0 0 00000000 11111111 0 0 11

//--- project.f
design/id_pkg.sv
design/inst_decoder.sv
design/regfile.sv
design/operand_fetch.sv
design/branch_resolve.sv
design/id_stage.sv
bench/id_stage_chk.sv
bench/id_stage_tb.sv

//--- bench/id_stage_tb.sv
module id_stage_tb
	import id_pkg::*;
();

	localparam int REC_W   = 22;
	localparam int REC_MAX = 64;

	logic      clk;
	logic      reset;
	logic      fs_to_ds_valid;
	fs_to_ds_t fs_to_ds;
	logic      es_allowin;
	fwd_src_t  fwd_es;
	fwd_src_t  fwd_ms;
	fwd_src_t  fwd_ws;
	rf_wr_t    rf_wr;
	logic      ds_allowin;
	logic      ds_to_es_valid;
	ds_to_es_t ds_to_es;
	br_bus_t   br_bus;

	logic [31:0]     stim [REC_MAX*REC_W];
	logic [XLEN-1:0] held_pc;
	int              n_rec;
	int              limit = 0;
	int              cycles = 0;
	int              err_ctrl = 0;
	int              err_ops = 0;
	int              err_pc = 0;
	int              err_br = 0;
	int              err_flow = 0;
	int              err_other = 0;

	id_stage i_dut (
		.clk            (clk),
		.reset          (reset),
		.fs_to_ds_valid (fs_to_ds_valid),
		.fs_to_ds       (fs_to_ds),
		.es_allowin     (es_allowin),
		.fwd_es         (fwd_es),
		.fwd_ms         (fwd_ms),
		.fwd_ws         (fwd_ws),
		.rf_wr          (rf_wr),
		.ds_allowin     (ds_allowin),
		.ds_to_es_valid (ds_to_es_valid),
		.ds_to_es       (ds_to_es),
		.br_bus         (br_bus)
	);

	initial
	begin
		clk = 1'b0;
	end

	always #20 clk = ~clk;

	// run limit is set once the records are counted
	always @(posedge clk)
	begin
		cycles++;
		if (limit != 0 && cycles > limit)
		begin
			$display("timeout: run did not finish within %0d cycles", limit);
			$display("Simulation failed");
			$finish;
		end
	end

	// meta word holds valid in bit 6, blocked in bit 5 and dest in the low bits
	function automatic fwd_src_t make_fwd(input logic [31:0] meta, input logic [31:0] data);
		fwd_src_t f;
		f.valid   = meta[6];
		f.blocked = meta[5];
		f.dest    = meta[4:0];
		f.data    = data;
		return f;
	endfunction

	function automatic dec_ctrl_t expected_ctrl(input int b);
		dec_ctrl_t e;
		e.alu_op      = alu_op_t'(stim[b+12][11:0]);
		e.load_op     = stim[b+13][7];
		e.load_sign   = stim[b+13][6];
		e.mem_size    = mem_size_t'(stim[b+13][5:4]);
		e.mem_we      = stim[b+13][3];
		e.gr_we       = stim[b+13][2];
		e.src1_is_pc  = stim[b+13][1];
		e.src2_is_imm = stim[b+13][0];
		e.dest        = stim[b+14][4:0];
		e.imm         = stim[b+15];
		e.br_kind     = br_kind_t'(stim[b+16][3:0]);
		return e;
	endfunction

	task automatic check_ctrl(input dec_ctrl_t got, input dec_ctrl_t exp, input int r);
		if (got !== exp)
		begin
			$display("[FAIL] record %0d ds_to_es.ctrl got %h expected %h", r, got, exp);
			err_ctrl++;
		end
	endtask

	task automatic check_operands(input operands_t got, input operands_t exp, input int r);
		if (got !== exp)
		begin
			$display("[FAIL] record %0d ds_to_es.operands got %h expected %h", r, got, exp);
			err_ops++;
		end
	endtask

	task automatic check_pc(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
		input int r);
		if (got !== exp)
		begin
			$display("[FAIL] record %0d ds_to_es.pc got %h expected %h", r, got, exp);
			err_pc++;
		end
	endtask

	task automatic check_br(input br_bus_t got, input br_bus_t exp, input int r);
		if (got !== exp)
		begin
			$display("[FAIL] record %0d br_bus got %h expected %h", r, got, exp);
			err_br++;
		end
	endtask

	// bit 1 ds_to_es_valid, bit 0 ds_allowin
	task automatic check_flow(input logic [1:0] got, input logic [1:0] exp, input int r);
		if (got !== exp)
		begin
			$display("[FAIL] record %0d ds_to_es_valid/ds_allowin got %h expected %h",
				r, got, exp);
			err_flow++;
		end
	endtask

	task automatic apply_inputs(input int b, input logic offer);
		fs_to_ds_valid <= offer;
		fs_to_ds       <= {stim[b+1], stim[b+2]};
		es_allowin     <= stim[b+3][0];
		fwd_es         <= make_fwd(stim[b+4], stim[b+5]);
		fwd_ms         <= make_fwd(stim[b+6], stim[b+7]);
		fwd_ws         <= make_fwd(stim[b+8], stim[b+9]);
		rf_wr          <= {stim[b+10][5], stim[b+10][4:0], stim[b+11]};
	endtask

	// kind 1 fetches and waits for the latch, 2 holds, 3 offers for one cycle
	task automatic run_record(input int r);
		int        b;
		logic [3:0] kind;
		logic [3:0] mask;
		operands_t exp_ops;
		br_bus_t   exp_br;
		b    = r * REC_W;
		kind = stim[b][3:0];
		mask = stim[b][7:4];
		if (kind < 1 || kind > 3)
		begin
			$display("record %0d has an unknown kind tag %h", r, kind);
			err_other++;
		end
		else
		begin
			@(posedge clk);
			apply_inputs(b, kind != 2);
			if (kind == 1)
			begin
				@(negedge clk);
				while (!ds_allowin)
					@(negedge clk);
				@(posedge clk);
				held_pc = stim[b+2];
				fs_to_ds_valid <= 1'b0;
				rf_wr.we       <= 1'b0;
			end
			@(negedge clk);
			exp_ops.rj_value  = stim[b+17];
			exp_ops.rkd_value = stim[b+18];
			exp_br.stall      = stim[b+19][4];
			exp_br.taken      = stim[b+19][0];
			exp_br.target     = stim[b+20];
			if (mask[0])
				check_ctrl(ds_to_es.ctrl, expected_ctrl(b), r);
			if (mask[1])
				check_operands(ds_to_es.operands, exp_ops, r);
			check_pc(ds_to_es.pc, held_pc, r);
			if (mask[2])
				check_br(br_bus, exp_br, r);
			if (mask[3])
				check_flow({ds_to_es_valid, ds_allowin}, {stim[b+21][4], stim[b+21][0]}, r);
		end
	endtask

	initial
	begin
		int total;
		reset          = 1'b1;
		fs_to_ds_valid = 1'b0;
		fs_to_ds       = '0;
		es_allowin     = 1'b1;
		fwd_es         = '0;
		fwd_ms         = '0;
		fwd_ws         = '0;
		rf_wr          = '0;
		held_pc        = '0;
		for (int i = 0; i < REC_MAX * REC_W; i++)
			stim[i] = '0;
		$readmemh("bench/id_stim.mem", stim);
		n_rec = 0;
		while (n_rec < REC_MAX && stim[n_rec*REC_W] != 0)
			n_rec++;
		limit = 4 * n_rec + 50;
		if (n_rec == 0)
		begin
			$display("no stimulus records were loaded");
			err_other++;
		end
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		for (int r = 0; r < n_rec; r++)
			run_record(r);
		total = err_ctrl + err_ops + err_pc + err_br + err_flow + err_other;
		$display("errors: ctrl %0d, operands %0d, pc %0d, branch %0d, flow %0d, other %0d",
			err_ctrl, err_ops, err_pc, err_br, err_flow, err_other);
		if (total == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- bench/id_stage_chk.sv
module id_stage_chk
	import id_pkg::*;
(
	input logic      clk,
	input logic      reset,
	input logic      fs_to_ds_valid,
	input logic      ds_allowin,
	input logic      es_allowin,
	input logic      ds_valid,
	input logic      ds_to_es_valid,
	input src_req_t  src,
	input fwd_src_t  fwd_es,
	input fwd_src_t  fwd_ms,
	input fwd_src_t  fwd_ws,
	input fs_to_ds_t fs_to_ds_r,
	input br_bus_t   br_bus
);

	logic src_blocked;

	function automatic logic blocks(input fwd_src_t f, input src_req_t s);
		return f.valid && f.blocked && (f.dest != '0)
			&& ((s.rs_used && f.dest == s.rs_addr) || (s.rt_used && f.dest == s.rt_addr));
	endfunction

	// any used source waiting on a blocked producer
	assign src_blocked = blocks(fwd_es, src) || blocks(fwd_ms, src) || blocks(fwd_ws, src);

	// an offered record was latched from fetch or kept from the cycle before
	a_valid_needs_stage: assert property (@(posedge clk) disable iff (reset)
		ds_to_es_valid |-> ds_valid && ($past(fs_to_ds_valid && ds_allowin)
			|| $past(ds_valid && !(ds_to_es_valid && es_allowin))))
		else $error("ds_to_es_valid high without a latched record");

	a_no_issue_on_hazard: assert property (@(posedge clk) disable iff (reset)
		src_blocked |-> !ds_to_es_valid)
		else $error("ds_to_es_valid high during a hazard");

	// back-pressure keeps the latched record
	a_hold_record: assert property (@(posedge clk) disable iff (reset)
		(ds_valid && !es_allowin) |=> ds_valid && $stable(fs_to_ds_r))
		else $error("latched record changed under back-pressure");

	a_stall_excludes_taken: assert property (@(posedge clk) disable iff (reset)
		(br_bus.stall || src_blocked) |-> !br_bus.taken)
		else $error("branch taken during a stall or hazard");

endmodule

bind id_stage id_stage_chk i_chk (
	.clk            (clk),
	.reset          (reset),
	.fs_to_ds_valid (fs_to_ds_valid),
	.ds_allowin     (ds_allowin),
	.es_allowin     (es_allowin),
	.ds_valid       (ds_valid),
	.ds_to_es_valid (ds_to_es_valid),
	.src            (src),
	.fwd_es         (fwd_es),
	.fwd_ms         (fwd_ms),
	.fwd_ws         (fwd_ws),
	.fs_to_ds_r     (fs_to_ds_r),
	.br_bus         (br_bus)
);

//--- design/id_stage.sv
module id_stage
	import id_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      fs_to_ds_valid,
	input  fs_to_ds_t fs_to_ds,
	input  logic      es_allowin,
	input  fwd_src_t  fwd_es,
	input  fwd_src_t  fwd_ms,
	input  fwd_src_t  fwd_ws,
	input  rf_wr_t    rf_wr,
	output logic      ds_allowin,
	output logic      ds_to_es_valid,
	output ds_to_es_t ds_to_es,
	output br_bus_t   br_bus
);

	logic            ds_valid;
	logic            ready_go;
	logic            hazard;
	fs_to_ds_t       fs_to_ds_r;
	dec_ctrl_t       ctrl;
	src_req_t        src;
	operands_t       operands;
	logic [XLEN-1:0] br_offs;

	assign ready_go       = !hazard;
	assign ds_allowin     = !ds_valid || (ready_go && es_allowin);
	assign ds_to_es_valid = ds_valid && ready_go;

	always_ff @(posedge clk)
	begin
		if (reset)
			ds_valid <= 1'b0;
		else if (ds_allowin)
			ds_valid <= fs_to_ds_valid;
	end

	always_ff @(posedge clk)
	begin
		if (fs_to_ds_valid && ds_allowin)
			fs_to_ds_r <= fs_to_ds;
	end

	inst_decoder i_decoder (
		.inst    (fs_to_ds_r.inst),
		.ctrl    (ctrl),
		.src     (src),
		.br_offs (br_offs)
	);

	operand_fetch i_operand_fetch (
		.clk      (clk),
		.src      (src),
		.rf_wr    (rf_wr),
		.fwd_es   (fwd_es),
		.fwd_ms   (fwd_ms),
		.fwd_ws   (fwd_ws),
		.operands (operands),
		.hazard   (hazard)
	);

	branch_resolve i_branch_resolve (
		.valid    (ds_valid),
		.hazard   (hazard),
		.br_kind  (ctrl.br_kind),
		.pc       (fs_to_ds_r.pc),
		.br_offs  (br_offs),
		.operands (operands),
		.br       (br_bus)
	);

	assign ds_to_es.ctrl     = ctrl;
	assign ds_to_es.operands = operands;
	assign ds_to_es.pc       = fs_to_ds_r.pc;

endmodule

//--- design/branch_resolve.sv
module branch_resolve
	import id_pkg::*;
(
	input  logic            valid,
	input  logic            hazard,
	input  br_kind_t        br_kind,
	input  logic [XLEN-1:0] pc,
	input  logic [XLEN-1:0] br_offs,
	input  operands_t       operands,
	output br_bus_t         br
);

	logic            eq, lt, ltu, cond;
	logic [XLEN-1:0] base;

	assign eq  = operands.rj_value == operands.rkd_value;
	assign lt  = $signed(operands.rj_value) < $signed(operands.rkd_value);
	assign ltu = operands.rj_value < operands.rkd_value;

	always_comb
	begin
		case (br_kind)
			BR_BEQ:               cond = eq;
			BR_BNE:               cond = !eq;
			BR_BLT:               cond = lt;
			BR_BGE:               cond = !lt;
			BR_BLTU:              cond = ltu;
			BR_BGEU:              cond = !ltu;
			BR_JIRL, BR_B, BR_BL: cond = 1'b1;
			default:              cond = 1'b0;
		endcase
	end

	// compare operands are stale under a hazard, so hold fetch instead
	assign br.stall  = valid && (br_kind != BR_NONE) && hazard;
	assign br.taken  = valid && !hazard && cond;

	assign base      = (br_kind == BR_JIRL) ? operands.rj_value : pc;
	assign br.target = base + br_offs;

endmodule

//--- design/operand_fetch.sv
module operand_fetch
	import id_pkg::*;
(
	input  logic      clk,
	input  src_req_t  src,
	input  rf_wr_t    rf_wr,
	input  fwd_src_t  fwd_es,
	input  fwd_src_t  fwd_ms,
	input  fwd_src_t  fwd_ws,
	output operands_t operands,
	output logic      hazard
);

	logic [XLEN-1:0] rf_rdata1;
	logic [XLEN-1:0] rf_rdata2;
	logic            rs_es, rs_ms, rs_ws;
	logic            rt_es, rt_ms, rt_ws;

	function automatic logic src_hit(
		input fwd_src_t          f,
		input logic [REG_AW-1:0] addr,
		input logic              used
	);
		return used && f.valid && (f.dest == addr);
	endfunction

	regfile i_regfile (
		.clk    (clk),
		.raddr1 (src.rs_addr),
		.rdata1 (rf_rdata1),
		.raddr2 (src.rt_addr),
		.rdata2 (rf_rdata2),
		.wr     (rf_wr)
	);

	assign rs_es = src_hit(fwd_es, src.rs_addr, src.rs_used);
	assign rs_ms = src_hit(fwd_ms, src.rs_addr, src.rs_used);
	assign rs_ws = src_hit(fwd_ws, src.rs_addr, src.rs_used);
	assign rt_es = src_hit(fwd_es, src.rt_addr, src.rt_used);
	assign rt_ms = src_hit(fwd_ms, src.rt_addr, src.rt_used);
	assign rt_ws = src_hit(fwd_ws, src.rt_addr, src.rt_used);

	// youngest producer wins
	assign operands.rj_value = rs_es ? fwd_es.data :
		rs_ms ? fwd_ms.data :
		rs_ws ? fwd_ws.data : rf_rdata1;
	assign operands.rkd_value = rt_es ? fwd_es.data :
		rt_ms ? fwd_ms.data :
		rt_ws ? fwd_ws.data : rf_rdata2;

	assign hazard = (fwd_es.blocked && (rs_es || rt_es))
		|| (fwd_ms.blocked && (rs_ms || rt_ms))
		|| (fwd_ws.blocked && (rs_ws || rt_ws));

endmodule

//--- design/regfile.sv
module regfile
	import id_pkg::*;
(
	input  logic              clk,
	input  logic [REG_AW-1:0] raddr1,
	output logic [XLEN-1:0]   rdata1,
	input  logic [REG_AW-1:0] raddr2,
	output logic [XLEN-1:0]   rdata2,
	input  rf_wr_t            wr
);

	logic [XLEN-1:0] regs [REG_NUM];

	always_ff @(posedge clk)
	begin
		if (wr.we)
			regs[wr.addr] <= wr.data;
	end

	// r0 reads as zero whatever was written to it
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- design/inst_decoder.sv
module inst_decoder
	import id_pkg::*;
(
	input  logic [XLEN-1:0] inst,
	output dec_ctrl_t       ctrl,
	output src_req_t        src,
	output logic [XLEN-1:0] br_offs
);

	logic [16:0]       op_31_15;
	logic [9:0]        op_31_22;
	logic [6:0]        op_31_25;
	logic [5:0]        op_31_26;
	logic [REG_AW-1:0] rd;
	logic [REG_AW-1:0] rj;
	logic [REG_AW-1:0] rk;
	logic [11:0]       i12;
	logic [19:0]       i20;
	logic [15:0]       i16;
	logic [25:0]       i26;
	alu_op_t           rr_op;
	alu_op_t           ri_op;
	br_kind_t          br_kind;
	logic              is_shift, is_rr, is_ri, is_ui12;
	logic              is_load, is_store, is_mem_h, is_mem_w;
	logic              is_lui, is_pcadd, is_link, is_cond, is_far, known;

	assign op_31_15 = inst[31:15];
	assign op_31_22 = inst[31:22];
	assign op_31_25 = inst[31:25];
	assign op_31_26 = inst[31:26];

	assign rd  = inst[4:0];
	assign rj  = inst[9:5];
	assign rk  = inst[14:10];
	assign i12 = inst[21:10];
	assign i20 = inst[24:5];
	assign i16 = inst[25:10];
	assign i26 = {inst[9:0], inst[25:10]};

	// shift-immediates share the alu encoding of the register forms
	always_comb
	begin
		case (op_31_15)
			OPC_ADD_W:              rr_op = ALU_ADD;
			OPC_SUB_W:              rr_op = ALU_SUB;
			OPC_SLT:                rr_op = ALU_SLT;
			OPC_SLTU:               rr_op = ALU_SLTU;
			OPC_NOR:                rr_op = ALU_NOR;
			OPC_AND:                rr_op = ALU_AND;
			OPC_OR:                 rr_op = ALU_OR;
			OPC_XOR:                rr_op = ALU_XOR;
			OPC_SLL_W, OPC_SLLI_W:  rr_op = ALU_SLL;
			OPC_SRL_W, OPC_SRLI_W:  rr_op = ALU_SRL;
			OPC_SRA_W, OPC_SRAI_W:  rr_op = ALU_SRA;
			default:                rr_op = ALU_NONE;
		endcase
	end

	always_comb
	begin
		case (op_31_22)
			OPC_SLTI:   ri_op = ALU_SLT;
			OPC_SLTUI:  ri_op = ALU_SLTU;
			OPC_ADDI_W: ri_op = ALU_ADD;
			OPC_ANDI:   ri_op = ALU_AND;
			OPC_ORI:    ri_op = ALU_OR;
			OPC_XORI:   ri_op = ALU_XOR;
			default:    ri_op = ALU_NONE;
		endcase
	end

	always_comb
	begin
		case (op_31_26)
			OPC_BEQ:  br_kind = BR_BEQ;
			OPC_BNE:  br_kind = BR_BNE;
			OPC_BLT:  br_kind = BR_BLT;
			OPC_BGE:  br_kind = BR_BGE;
			OPC_BLTU: br_kind = BR_BLTU;
			OPC_BGEU: br_kind = BR_BGEU;
			OPC_JIRL: br_kind = BR_JIRL;
			OPC_B:    br_kind = BR_B;
			OPC_BL:   br_kind = BR_BL;
			default:  br_kind = BR_NONE;
		endcase
	end

	assign is_shift = op_31_15 inside {OPC_SLLI_W, OPC_SRLI_W, OPC_SRAI_W};
	assign is_rr    = (rr_op != ALU_NONE) && !is_shift;
	assign is_ri    = ri_op != ALU_NONE;
	assign is_ui12  = op_31_22 inside {OPC_ANDI, OPC_ORI, OPC_XORI};
	assign is_load  = op_31_22 inside {OPC_LD_B, OPC_LD_H, OPC_LD_W, OPC_LD_BU, OPC_LD_HU};
	assign is_store = op_31_22 inside {OPC_ST_B, OPC_ST_H, OPC_ST_W};
	assign is_mem_h = op_31_22 inside {OPC_LD_H, OPC_LD_HU, OPC_ST_H};
	assign is_mem_w = op_31_22 inside {OPC_LD_W, OPC_ST_W};
	assign is_lui   = op_31_25 == OPC_LU12I_W;
	assign is_pcadd = op_31_25 == OPC_PCADDU12I;
	assign is_link  = br_kind inside {BR_JIRL, BR_BL};
	assign is_cond  = br_kind inside {BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};
	assign is_far   = br_kind inside {BR_B, BR_BL};
	assign known    = is_rr || is_shift || is_ri || is_load || is_store || is_lui || is_pcadd
		|| (br_kind != BR_NONE);

	// link address is pc + 4 through the adder
	assign ctrl.alu_op = is_lui ? ALU_LUI :
		(is_load || is_store || is_pcadd || is_link) ? ALU_ADD :
		is_ri ? ri_op : rr_op;
	assign ctrl.load_op     = is_load;
	assign ctrl.load_sign   = op_31_22 inside {OPC_LD_B, OPC_LD_H};
	assign ctrl.mem_size    = is_mem_w ? MEM_WORD : is_mem_h ? MEM_HALF : MEM_BYTE;
	assign ctrl.mem_we      = is_store;
	assign ctrl.gr_we       = is_rr || is_shift || is_ri || is_load || is_lui || is_pcadd
		|| is_link;
	assign ctrl.src1_is_pc  = is_pcadd || is_link;
	assign ctrl.src2_is_imm = is_shift || is_ri || is_load || is_store || is_lui || is_pcadd
		|| is_link;
	assign ctrl.dest        = !known ? '0 : (br_kind == BR_BL) ? REG_AW'(1) : rd;
	assign ctrl.br_kind     = br_kind;

	assign ctrl.imm = is_link ? XLEN'(4) :
		(is_lui || is_pcadd) ? {i20, 12'b0} :
		is_ui12 ? {20'b0, i12} :
		(is_shift || is_ri || is_load || is_store) ? {{20{i12[11]}}, i12} : '0;

	assign br_offs = is_far ? {{4{i26[25]}}, i26, 2'b0} : {{14{i16[15]}}, i16, 2'b0};

	// stores and compares read rd on the second port
	assign src.rs_addr = rj;
	assign src.rs_used = known && !is_lui && !is_pcadd && !is_far && (rj != '0);
	assign src.rt_addr = (is_cond || is_store) ? rd : rk;
	assign src.rt_used = (is_rr || is_cond || is_store) && (src.rt_addr != '0);

endmodule

//--- design/id_pkg.sv
package id_pkg;

	localparam int XLEN    = 32;
	localparam int REG_AW  = 5;
	localparam int REG_NUM = 32;

	// 3R and shift-immediate forms matched on inst[31:15]
	localparam logic [16:0] OPC_ADD_W  = 17'h00020;
	localparam logic [16:0] OPC_SUB_W  = 17'h00022;
	localparam logic [16:0] OPC_SLT    = 17'h00024;
	localparam logic [16:0] OPC_SLTU   = 17'h00025;
	localparam logic [16:0] OPC_NOR    = 17'h00028;
	localparam logic [16:0] OPC_AND    = 17'h00029;
	localparam logic [16:0] OPC_OR     = 17'h0002a;
	localparam logic [16:0] OPC_XOR    = 17'h0002b;
	localparam logic [16:0] OPC_SLL_W  = 17'h0002e;
	localparam logic [16:0] OPC_SRL_W  = 17'h0002f;
	localparam logic [16:0] OPC_SRA_W  = 17'h00030;
	localparam logic [16:0] OPC_SLLI_W = 17'h00081;
	localparam logic [16:0] OPC_SRLI_W = 17'h00089;
	localparam logic [16:0] OPC_SRAI_W = 17'h00091;

	// 2RI12 forms on inst[31:22]
	localparam logic [9:0] OPC_SLTI   = 10'h008;
	localparam logic [9:0] OPC_SLTUI  = 10'h009;
	localparam logic [9:0] OPC_ADDI_W = 10'h00a;
	localparam logic [9:0] OPC_ANDI   = 10'h00d;
	localparam logic [9:0] OPC_ORI    = 10'h00e;
	localparam logic [9:0] OPC_XORI   = 10'h00f;
	localparam logic [9:0] OPC_LD_B   = 10'h0a0;
	localparam logic [9:0] OPC_LD_H   = 10'h0a1;
	localparam logic [9:0] OPC_LD_W   = 10'h0a2;
	localparam logic [9:0] OPC_ST_B   = 10'h0a4;
	localparam logic [9:0] OPC_ST_H   = 10'h0a5;
	localparam logic [9:0] OPC_ST_W   = 10'h0a6;
	localparam logic [9:0] OPC_LD_BU  = 10'h0a8;
	localparam logic [9:0] OPC_LD_HU  = 10'h0a9;

	// 1RI20 forms on inst[31:25]
	localparam logic [6:0] OPC_LU12I_W   = 7'h0a;
	localparam logic [6:0] OPC_PCADDU12I = 7'h0e;

	// branches on inst[31:26]
	localparam logic [5:0] OPC_JIRL = 6'h13;
	localparam logic [5:0] OPC_B    = 6'h14;
	localparam logic [5:0] OPC_BL   = 6'h15;
	localparam logic [5:0] OPC_BEQ  = 6'h16;
	localparam logic [5:0] OPC_BNE  = 6'h17;
	localparam logic [5:0] OPC_BLT  = 6'h18;
	localparam logic [5:0] OPC_BGE  = 6'h19;
	localparam logic [5:0] OPC_BLTU = 6'h1a;
	localparam logic [5:0] OPC_BGEU = 6'h1b;

	// one-hot with add in bit 0
	typedef enum logic [11:0] {
		ALU_NONE = 12'h000, ALU_ADD = 12'h001, ALU_SUB = 12'h002, ALU_SLT = 12'h004,
		ALU_SLTU = 12'h008, ALU_AND = 12'h010, ALU_NOR = 12'h020, ALU_OR  = 12'h040,
		ALU_XOR  = 12'h080, ALU_SLL = 12'h100, ALU_SRL = 12'h200, ALU_SRA = 12'h400,
		ALU_LUI  = 12'h800
	} alu_op_t;

	typedef enum logic [1:0] {
		MEM_BYTE = 2'd0,
		MEM_HALF = 2'd1,
		MEM_WORD = 2'd2
	} mem_size_t;

	typedef enum logic [3:0] {
		BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE,
		BR_BLTU, BR_BGEU, BR_JIRL, BR_B, BR_BL
	} br_kind_t;

	typedef struct packed {
		logic [XLEN-1:0] inst;
		logic [XLEN-1:0] pc;
	} fs_to_ds_t;

	// used is clear for register 0
	typedef struct packed {
		logic [REG_AW-1:0] rs_addr;
		logic              rs_used;
		logic [REG_AW-1:0] rt_addr;
		logic              rt_used;
	} src_req_t;

	typedef struct packed {
		alu_op_t           alu_op;
		logic              load_op;
		logic              load_sign;
		mem_size_t         mem_size;
		logic              mem_we;
		logic              gr_we;
		logic              src1_is_pc;
		logic              src2_is_imm;
		logic [REG_AW-1:0] dest;
		logic [XLEN-1:0]   imm;
		br_kind_t          br_kind;
	} dec_ctrl_t;

	// blocked marks a result that is not ready yet such as a load in execute
	typedef struct packed {
		logic              valid;
		logic              blocked;
		logic [REG_AW-1:0] dest;
		logic [XLEN-1:0]   data;
	} fwd_src_t;

	typedef struct packed {
		logic              we;
		logic [REG_AW-1:0] addr;
		logic [XLEN-1:0]   data;
	} rf_wr_t;

	typedef struct packed {
		logic [XLEN-1:0] rj_value;
		logic [XLEN-1:0] rkd_value;
	} operands_t;

	typedef struct packed {
		dec_ctrl_t       ctrl;
		operands_t       operands;
		logic [XLEN-1:0] pc;
	} ds_to_es_t;

	typedef struct packed {
		logic            stall;
		logic            taken;
		logic [XLEN-1:0] target;
	} br_bus_t;

endpackage
